/* src/rv32_ctrl_cfg.svh */
// Build-time constants for the two-stage pipeline control subsystem
`ifndef RV32_CTRL_CFG_SVH
`define RV32_CTRL_CFG_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0200

// Direct-mode machine trap vector, no vectored entries
`define MTVEC_BASE 32'h0000_0100

// Global machine interrupt enable out of reset
`define MIE_RESET 1'b1

// Retired instruction counter width, wraps silently
`define INSTRET_W 16

`endif

/* src/rv32i_types_pkg.sv */
// Base RV32I word and instruction address types
package rv32i_types_pkg;

  // Raw 32-bit data value, used for fault addresses and mtval
  typedef logic [31:0] word_t;

  // Byte address of an instruction
  typedef logic [31:0] addr_t;

  // Byte distance between sequential instructions, no compressed ISA
  localparam addr_t insn_step = 32'd4;

  // Mask for the trap vector and return targets
  localparam addr_t addr_align_mask = 32'hffff_fffc;

endpackage

/* src/priv_types_pkg.sv */
// Machine-mode trap cause codes and trap controller state encoding
package priv_types_pkg;

  // mcause layout, bit 31 flags an interrupt
  typedef logic [31:0] cause_t;

  // Synchronous exception codes
  localparam cause_t cause_insn_mal    = 32'd0;
  localparam cause_t cause_insn_fault  = 32'd1;
  localparam cause_t cause_illegal     = 32'd2;
  localparam cause_t cause_breakpoint  = 32'd3;
  localparam cause_t cause_load_mal    = 32'd4;
  localparam cause_t cause_load_fault  = 32'd5;
  localparam cause_t cause_store_mal   = 32'd6;
  localparam cause_t cause_store_fault = 32'd7;
  localparam cause_t cause_env_m       = 32'd11; // ecall from M-mode

  // Machine external interrupt
  localparam cause_t cause_ext_irq     = 32'h8000_000b;

  // Trap controller sequencing
  typedef enum logic [1:0] {
    trap_idle,   // Normal flow
    trap_insert, // Redirect fetch to mtvec
    trap_return  // Redirect fetch to mepc
  } trap_state_t;

endpackage

/* src/hazard_unit.sv */
// Stall, flush and next-PC control for the two-stage fetch/execute pipeline
`timescale 1ns/1ps

module hazard_unit (
  input  logic                   i_mem_busy,     // Fetch not answered yet
  input  logic                   dren,           // Load in execute
  input  logic                   dwen,           // Store in execute
  input  logic                   d_mem_busy,     // Data access not answered yet
  input  logic                   jump,
  input  logic                   branch,
  input  logic                   mispredict,
  input  logic                   halt,
  input  logic                   token_ex,       // Valid instruction in execute
  input  logic                   ret,            // mret in execute
  input  logic                   fault_insn,
  input  logic                   mal_insn,
  input  logic                   illegal_insn,
  input  logic                   fault_l,
  input  logic                   mal_l,
  input  logic                   fault_s,
  input  logic                   mal_s,
  input  logic                   breakpoint,
  input  logic                   env_m,
  input  rv32i_types_pkg::addr_t epc_e,          // PC of execute instruction
  input  rv32i_types_pkg::word_t badaddr_e,      // Faulting data address
  input  rv32i_types_pkg::addr_t pc,             // Current fetch address
  input  logic                   intr,           // Interrupt pending from trap block
  input  logic                   insert_pc,
  input  rv32i_types_pkg::addr_t priv_pc,
  output logic                   iren,
  output logic                   pc_en,
  output logic                   npc_sel,        // Take branch_target
  output logic                   insert_priv_pc,
  output rv32i_types_pkg::addr_t fetch_priv_pc,
  output logic                   if_ex_flush,
  output logic                   if_ex_stall,
  output logic                   pipe_clear,
  output logic                   wb_enable,
  output logic                   ret_req,
  output rv32i_types_pkg::addr_t epc,
  output rv32i_types_pkg::word_t badaddr,
  output logic                   prv_fault_insn,
  output logic                   prv_mal_insn,
  output logic                   prv_illegal_insn,
  output logic                   prv_fault_l,
  output logic                   prv_mal_l,
  output logic                   prv_fault_s,
  output logic                   prv_mal_s,
  output logic                   prv_breakpoint,
  output logic                   prv_env_m
);
  import rv32i_types_pkg::*;

  logic  dmem_access;
  logic  branch_jump;
  logic  wait_for_imem;
  logic  wait_for_dmem;
  logic  ex_flush_hazard;
  logic  e_ex_stage;
  logic  e_f_stage;
  logic  intr_take;
  addr_t epc_f;     // Fetch-stage trap PC
  word_t badaddr_f; // Fetch-stage fault address

  assign epc_f     = pc;
  assign badaddr_f = pc;

  assign dmem_access   = dren | dwen;
  assign branch_jump   = jump | (branch & mispredict); // Correct predictions fall through
  assign wait_for_imem = iren & i_mem_busy;
  assign wait_for_dmem = dmem_access & d_mem_busy;

  // Exception groups by stage
  assign e_ex_stage = illegal_insn | fault_l | mal_l | fault_s | mal_s | breakpoint | env_m;
  assign e_f_stage  = fault_insn | mal_insn;
  assign intr_take  = intr & ~e_ex_stage & ~e_f_stage; // Exceptions outrank interrupt

  // Execute is empty and no data access outstanding, so an interrupt loses nothing
  assign pipe_clear = e_ex_stage | (~token_ex & ~wait_for_dmem);

  assign ex_flush_hazard = ((intr_take | e_f_stage) & ~wait_for_dmem) | e_ex_stage | ret;

  // Redirects override a memory stall
  assign pc_en = (~wait_for_dmem & ~wait_for_imem & ~halt & ~ex_flush_hazard) |
                 branch_jump | insert_pc | ret;

  assign npc_sel        = branch_jump;
  assign insert_priv_pc = insert_pc;
  assign fetch_priv_pc  = priv_pc;

  // Fetch wait during a finishing data access drops the fetched slot
  assign if_ex_flush = ex_flush_hazard | branch_jump |
                       (wait_for_imem & dmem_access & ~d_mem_busy);

  assign if_ex_stall = (wait_for_dmem | (wait_for_imem & ~dmem_access) | halt) &
                       (~ex_flush_hazard | e_ex_stage);

  assign iren = ~intr_take; // No fetch request while the trap is taken

  // Two stages, so a redirect still retires the execute instruction
  assign wb_enable = ~if_ex_stall | jump | branch;
  assign ret_req   = ret;

  // Flags forwarded unchanged to the trap block
  assign prv_fault_insn   = fault_insn;
  assign prv_mal_insn     = mal_insn;
  assign prv_illegal_insn = illegal_insn;
  assign prv_fault_l      = fault_l;
  assign prv_mal_l        = mal_l;
  assign prv_fault_s      = fault_s;
  assign prv_mal_s        = mal_s;
  assign prv_breakpoint   = breakpoint;
  assign prv_env_m        = env_m;

  assign epc     = e_ex_stage ? epc_e : epc_f;     // Interrupt resumes at fetch PC
  assign badaddr = e_f_stage ? badaddr_f : badaddr_e;

endmodule

/* src/pc_unit.sv */
// Fetch program counter with branch, trap and sequential next-PC selection
`timescale 1ns/1ps

`include "rv32_ctrl_cfg.svh"

module pc_unit (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   pc_en,          // Advance fetch this cycle
  input  logic                   npc_sel,        // Branch or jump redirect
  input  logic                   insert_priv_pc, // Trap entry or mret
  input  rv32i_types_pkg::addr_t priv_pc,
  input  rv32i_types_pkg::addr_t branch_target,
  output rv32i_types_pkg::addr_t pc
);
  import rv32i_types_pkg::*;

  addr_t pc_plus4;
  addr_t npc;

  assign pc_plus4 = pc + insn_step;

  // Trap redirect wins over branch, branch over sequential
  always_comb begin
    if (insert_priv_pc) begin
      npc = priv_pc;
    end else if (npc_sel) begin
      npc = branch_target;
    end else begin
      npc = pc_plus4;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (pc_en) begin
      pc <= npc; // Holds while stalled
    end
  end

endmodule

/* src/priv_unit.sv */
// Reduced machine-mode trap controller with mret and retired instruction count
`timescale 1ns/1ps

`include "rv32_ctrl_cfg.svh"

module priv_unit (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   ext_irq,      // Level from the interrupt source
  input  logic                   pipe_clear,   // Safe point for an interrupt
  input  logic                   wb_enable,    // Execute instruction completes
  input  logic                   ret_req,      // mret
  input  logic                   fault_insn,
  input  logic                   mal_insn,
  input  logic                   illegal_insn,
  input  logic                   fault_l,
  input  logic                   mal_l,
  input  logic                   fault_s,
  input  logic                   mal_s,
  input  logic                   breakpoint,
  input  logic                   env_m,
  input  rv32i_types_pkg::addr_t epc,
  input  rv32i_types_pkg::word_t badaddr,
  output logic                   intr,
  output logic                   insert_pc,
  output rv32i_types_pkg::addr_t priv_pc,
  output rv32i_types_pkg::addr_t mepc,
  output priv_types_pkg::cause_t mcause,
  output rv32i_types_pkg::word_t mtval,
  output logic [`INSTRET_W-1:0]  instret
);
  import rv32i_types_pkg::*;
  import priv_types_pkg::*;

  trap_state_t state;
  trap_state_t state_next;
  logic        mie;        // Global machine interrupt enable
  logic        exc_any;
  logic        trap_take;
  cause_t      trap_cause;
  word_t       trap_tval;

  assign exc_any = fault_insn | mal_insn | illegal_insn | fault_l | mal_l |
                   fault_s | mal_s | breakpoint | env_m;

  // Only one interrupt accepted until mret restores mie
  assign intr      = ext_irq & mie & pipe_clear & (state == trap_idle);
  assign trap_take = exc_any | intr;

  // Fixed cause ranking, interrupt last
  always_comb begin
    trap_cause = cause_ext_irq;
    trap_tval  = '0;
    if (mal_insn) begin
      trap_cause = cause_insn_mal;
      trap_tval  = badaddr;
    end else if (fault_insn) begin
      trap_cause = cause_insn_fault;
      trap_tval  = badaddr;
    end else if (illegal_insn) begin
      trap_cause = cause_illegal;
    end else if (breakpoint) begin
      trap_cause = cause_breakpoint;
    end else if (env_m) begin
      trap_cause = cause_env_m;
    end else if (mal_l) begin
      trap_cause = cause_load_mal;
      trap_tval  = badaddr;
    end else if (fault_l) begin
      trap_cause = cause_load_fault;
      trap_tval  = badaddr;
    end else if (mal_s) begin
      trap_cause = cause_store_mal;
      trap_tval  = badaddr;
    end else if (fault_s) begin
      trap_cause = cause_store_fault;
      trap_tval  = badaddr;
    end
  end

  // Each redirect lasts exactly one cycle
  always_comb begin
    if (trap_take) begin
      state_next = trap_insert;
    end else if (ret_req) begin
      state_next = trap_return;
    end else begin
      state_next = trap_idle;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state  <= trap_idle;
      mie    <= `MIE_RESET;
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else begin
      state <= state_next;
      if (trap_take) begin
        mepc   <= epc;
        mcause <= trap_cause;
        mtval  <= trap_tval;
        mie    <= 1'b0; // Mask further interrupts inside the handler
      end else if (ret_req) begin
        mie <= 1'b1;
      end
    end
  end

  assign insert_pc = (state != trap_idle);
  assign priv_pc   = (state == trap_return) ? (mepc & addr_align_mask) :
                                              (`MTVEC_BASE & addr_align_mask);

  // Excepting instructions do not retire
  always_ff @(posedge CLK) begin
    if (reset) begin
      instret <= '0;
    end else if (wb_enable && !exc_any) begin
      instret <= instret + 1'b1; // Wraps at INSTRET_W bits
    end
  end

endmodule

/* src/pipe_ctrl_top.sv */
// Pipeline control subsystem joining hazard control, fetch PC and trap handling
`timescale 1ns/1ps

`include "rv32_ctrl_cfg.svh"

module pipe_ctrl_top (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   i_mem_busy,
  input  logic                   dren,
  input  logic                   dwen,
  input  logic                   d_mem_busy,
  input  logic                   jump,
  input  logic                   branch,
  input  logic                   mispredict,
  input  rv32i_types_pkg::addr_t branch_target,
  input  logic                   halt,
  input  logic                   token_ex,
  input  logic                   ret,
  input  logic                   fault_insn,
  input  logic                   mal_insn,
  input  logic                   illegal_insn,
  input  logic                   fault_l,
  input  logic                   mal_l,
  input  logic                   fault_s,
  input  logic                   mal_s,
  input  logic                   breakpoint,
  input  logic                   env_m,
  input  rv32i_types_pkg::addr_t epc_e,
  input  rv32i_types_pkg::word_t badaddr_e,
  input  logic                   ext_irq,
  output rv32i_types_pkg::addr_t pc,
  output logic                   iren,
  output logic                   if_ex_flush,
  output logic                   if_ex_stall,
  output rv32i_types_pkg::addr_t mepc,
  output priv_types_pkg::cause_t mcause,
  output rv32i_types_pkg::word_t mtval,
  output logic [`INSTRET_W-1:0]  instret
);
  import rv32i_types_pkg::*;

  // Hazard to fetch PC
  logic  pc_en;
  logic  npc_sel;
  logic  insert_priv_pc;
  addr_t fetch_priv_pc;

  // Hazard to trap block
  logic  pipe_clear;
  logic  wb_enable;
  logic  ret_req;
  addr_t epc;
  word_t badaddr;
  logic  prv_fault_insn;
  logic  prv_mal_insn;
  logic  prv_illegal_insn;
  logic  prv_fault_l;
  logic  prv_mal_l;
  logic  prv_fault_s;
  logic  prv_mal_s;
  logic  prv_breakpoint;
  logic  prv_env_m;

  // Trap block back to hazard
  logic  intr;
  logic  insert_pc;
  addr_t priv_pc;

  // Port names match the wires above
  hazard_unit hazard_unit_inst (.*);

  pc_unit pc_unit_inst (
    .*,
    .priv_pc (fetch_priv_pc) // Forwarded trap target
  );

  priv_unit priv_unit_inst (
    .*,
    .fault_insn   (prv_fault_insn),
    .mal_insn     (prv_mal_insn),
    .illegal_insn (prv_illegal_insn),
    .fault_l      (prv_fault_l),
    .mal_l        (prv_mal_l),
    .fault_s      (prv_fault_s),
    .mal_s        (prv_mal_s),
    .breakpoint   (prv_breakpoint),
    .env_m        (prv_env_m)
  );

endmodule

/* dv/pipe_ctrl_tb.sv */
// Vector-driven self-checking testbench for the pipeline control subsystem
`timescale 1ns/1ps

`include "rv32_ctrl_cfg.svh"

module pipe_ctrl_tb;
  import rv32i_types_pkg::*;
  import priv_types_pkg::*;

  localparam string vec_file     = "dv/pipe_ctrl_input.txt";
  localparam int    reset_cycles = 16;
  localparam int    margin_ns    = 200; // Covers reset and the last vector

  logic                  CLK;
  logic                  reset;
  logic                  i_mem_busy;
  logic                  dren;
  logic                  dwen;
  logic                  d_mem_busy;
  logic                  jump;
  logic                  branch;
  logic                  mispredict;
  addr_t                 branch_target;
  logic                  halt;
  logic                  token_ex;
  logic                  ret;
  logic                  fault_insn;
  logic                  mal_insn;
  logic                  illegal_insn;
  logic                  fault_l;
  logic                  mal_l;
  logic                  fault_s;
  logic                  mal_s;
  logic                  breakpoint;
  logic                  env_m;
  addr_t                 epc_e;
  word_t                 badaddr_e;
  logic                  ext_irq;
  addr_t                 pc;
  logic                  iren;
  logic                  if_ex_flush;
  logic                  if_ex_stall;
  addr_t                 mepc;
  cause_t                mcause;
  word_t                 mtval;
  logic [`INSTRET_W-1:0] instret;

  // Stimulus columns with one entry per cycle
  logic [3:0]            vec_mem[$];      // i_mem_busy dren dwen d_mem_busy
  logic [4:0]            vec_flow[$];     // jump branch mispredict halt ret
  logic                  vec_tok[$];
  logic                  vec_irq[$];
  logic [8:0]            vec_exc[$];      // Exception flags with fetch faults first
  addr_t                 vec_tgt[$];
  addr_t                 vec_epc[$];
  word_t                 vec_bad[$];

  // Expected columns
  addr_t                 exp_pc[$];
  logic                  exp_flush[$];
  logic                  exp_stall[$];
  addr_t                 exp_mepc[$];
  cause_t                exp_mcause[$];
  word_t                 exp_mtval[$];
  logic [`INSTRET_W-1:0] exp_instret[$];

  int vec_count   = 0;
  int check_count = 0;
  int error_count = 0;
  bit loaded      = 1'b0; // Releases the watchdog

  pipe_ctrl_top pipe_ctrl_top_inst (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK; // 4 ns period
  end

  task automatic init_inputs();
    reset <= 1'b1;
    {i_mem_busy, dren, dwen, d_mem_busy} <= '0;
    {jump, branch, mispredict, halt, ret} <= '0;
    token_ex <= 1'b0;
    ext_irq  <= 1'b0;
    {fault_insn, mal_insn, illegal_insn, fault_l, mal_l} <= '0;
    {fault_s, mal_s, breakpoint, env_m} <= '0;
    branch_target <= '0;
    epc_e         <= '0;
    badaddr_e     <= '0;
  endtask

  task automatic load_vectors();
    int                    fd;
    int                    line_no;
    int                    fields;
    string                 line;
    logic [3:0]            mem;
    logic [4:0]            flow;
    logic                  tok;
    logic                  irq;
    logic [8:0]            exc;
    addr_t                 tgt;
    addr_t                 epc_v;
    word_t                 bad;
    addr_t                 pc_v;
    logic                  flush_v;
    logic                  stall_v;
    addr_t                 mepc_v;
    cause_t                mcause_v;
    word_t                 mtval_v;
    logic [`INSTRET_W-1:0] instret_v;
    line_no = 0;
    fd = $fopen(vec_file, "r");
    if (fd == 0) begin
      $display("Could not open %s for reading", vec_file);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue; // Blank or column notes
      end
      fields = $sscanf(line, "%b %b %b %b %b %h %h %h %h %b %b %h %h %h %h",
                       mem, flow, tok, irq, exc, tgt, epc_v, bad,
                       pc_v, flush_v, stall_v, mepc_v, mcause_v, mtval_v, instret_v);
      if (fields != 15) begin
        $display("Malformed vector on line %0d of %s", line_no, vec_file);
        error_count++;
        continue;
      end
      vec_mem.push_back(mem);
      vec_flow.push_back(flow);
      vec_tok.push_back(tok);
      vec_irq.push_back(irq);
      vec_exc.push_back(exc);
      vec_tgt.push_back(tgt);
      vec_epc.push_back(epc_v);
      vec_bad.push_back(bad);
      exp_pc.push_back(pc_v);
      exp_flush.push_back(flush_v);
      exp_stall.push_back(stall_v);
      exp_mepc.push_back(mepc_v);
      exp_mcause.push_back(mcause_v);
      exp_mtval.push_back(mtval_v);
      exp_instret.push_back(instret_v);
    end
    $fclose(fd);
  endtask

  // Called right after a rising edge
  task automatic apply_vector(input int i);
    {i_mem_busy, dren, dwen, d_mem_busy} <= vec_mem[i];
    {jump, branch, mispredict, halt, ret} <= vec_flow[i];
    token_ex <= vec_tok[i];
    ext_irq  <= vec_irq[i];
    {fault_insn, mal_insn, illegal_insn, fault_l, mal_l,
     fault_s, mal_s, breakpoint, env_m} <= vec_exc[i];
    branch_target <= vec_tgt[i];
    epc_e         <= vec_epc[i];
    badaddr_e     <= vec_bad[i];
  endtask

  task automatic check_value(input string name, input int vec,
                             input logic [31:0] actual, input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] vector %0d %s: got 0x%h, expected 0x%h", vec, name, actual, expected);
    end
  endtask

  task automatic check_outputs(input int i);
    logic irq_entry; // Next edge records a new interrupt trap
    irq_entry = (i + 1 < vec_count) && exp_mcause[i+1][31] &&
                (exp_mcause[i+1] != exp_mcause[i] || exp_mepc[i+1] != exp_mepc[i]);
    check_value("pc", i, pc, exp_pc[i]);
    check_value("iren", i, 32'(iren), 32'(!irq_entry)); // No fetch while taking the interrupt
    check_value("if_ex_flush", i, 32'(if_ex_flush), 32'(exp_flush[i]));
    check_value("if_ex_stall", i, 32'(if_ex_stall), 32'(exp_stall[i]));
    check_value("mepc", i, mepc, exp_mepc[i]);
    check_value("mcause", i, mcause, exp_mcause[i]);
    check_value("mtval", i, mtval, exp_mtval[i]);
    check_value("instret", i, 32'(instret), 32'(exp_instret[i]));
  endtask

  initial begin
    init_inputs();
    load_vectors();
    vec_count = vec_mem.size();
    if (vec_count == 0) begin
      $display("No vectors were read from %s", vec_file);
      error_count++;
    end
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    reset <= 1'b0; // First vector shares this edge
    for (int i = 0; i < vec_count; i++) begin
      apply_vector(i);
      @(negedge CLK); // Mid-cycle where outputs have settled
      check_outputs(i);
      @(posedge CLK);
    end
    $display("Summary: %0d vectors, %0d checks, %0d errors", vec_count, check_count, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Two clock periods per vector plus margin
  initial begin
    int timeout_ns;
    wait (loaded);
    timeout_ns = vec_count * 8 + margin_ns;
    #(timeout_ns);
    $display("Watchdog expired after %0d ns before the last vector was checked", timeout_ns);
    $display("tests failed");
    $finish;
  end

endmodule

/* dv/pipe_ctrl_input.txt */
# mem[imb dren dwen dmb] flow[jump br mispred halt ret] tok irq exc[fi mi ill fl ml fs ms bp ecall]
# tgt epc_e badaddr_e, then expected: pc flush stall mepc mcause mtval instret
0000 00000 1 0 000000000 0000 0000 0000 0200 0 0 0000 00000000 0000 0000
0000 00000 1 0 000000000 0000 0000 0000 0204 0 0 0000 00000000 0000 0001
0000 00000 1 0 000000000 0000 0000 0000 0208 0 0 0000 00000000 0000 0002
0000 10000 1 0 000000000 0300 0000 0000 020c 1 0 0000 00000000 0000 0003
0000 01100 1 0 000000000 0340 0000 0000 0300 1 0 0000 00000000 0000 0004
0000 01000 1 0 000000000 0500 0000 0000 0340 0 0 0000 00000000 0000 0005
1000 00000 1 0 000000000 0000 0000 0000 0344 0 1 0000 00000000 0000 0006
0101 00000 1 0 000000000 0000 0000 0000 0344 0 1 0000 00000000 0000 0006
0011 00000 1 0 000000000 0000 0000 0000 0344 0 1 0000 00000000 0000 0006
0000 00010 1 0 000000000 0000 0000 0000 0344 0 1 0000 00000000 0000 0006
1100 00000 1 0 000000000 0000 0000 0000 0344 1 0 0000 00000000 0000 0006
0000 00000 1 0 000000000 0000 0000 0000 0344 0 0 0000 00000000 0000 0007
1000 10000 1 0 000000000 0400 0000 0000 0348 1 1 0000 00000000 0000 0008
0000 00000 1 0 000000000 0000 0000 0000 0400 0 0 0000 00000000 0000 0009
0000 00000 0 1 000000000 0000 0000 0000 0404 1 0 0000 00000000 0000 000a
0000 00000 0 1 000000000 0000 0000 0000 0404 0 0 0404 8000000b 0000 000b
0000 00000 0 1 000000000 0000 0000 0000 0100 0 0 0404 8000000b 0000 000c
0000 00000 1 1 000000000 0000 0000 0000 0104 0 0 0404 8000000b 0000 000d
0000 00001 1 0 000000000 0000 0000 0000 0108 1 0 0404 8000000b 0000 000e
0000 00000 0 0 000000000 0000 0000 0000 010c 0 0 0404 8000000b 0000 000f
0000 00000 1 0 000000000 0000 0000 0000 0404 0 0 0404 8000000b 0000 0010
0000 00000 1 0 000000000 0000 0000 0000 0408 0 0 0404 8000000b 0000 0011
0000 00000 1 0 001000000 0000 0408 0123 040c 1 0 0404 8000000b 0000 0012
0000 00000 0 0 000000000 0000 0000 0000 040c 0 0 0408 00000002 0000 0012
0000 00000 1 0 000000000 0000 0000 0000 0100 0 0 0408 00000002 0000 0013
0100 00000 1 0 000100000 0000 0100 8000 0104 1 0 0408 00000002 0000 0014
0000 00000 0 0 000000000 0000 0000 0000 0104 0 0 0100 00000005 8000 0014
0000 00000 1 0 000000000 0000 0000 0000 0100 0 0 0100 00000005 8000 0015
0000 00000 1 0 000000000 0000 0000 0000 0104 0 0 0100 00000005 8000 0016
0100 00000 1 0 000011000 0000 0104 8002 0108 1 0 0100 00000005 8000 0017
0000 00000 0 0 000000000 0000 0000 0000 0108 0 0 0104 00000004 8002 0017
0000 00000 1 0 000000000 0000 0000 0000 0100 0 0 0104 00000004 8002 0018

/* compile.f */
+incdir+src
src/rv32i_types_pkg.sv
src/priv_types_pkg.sv
src/hazard_unit.sv
src/pc_unit.sv
src/priv_unit.sv
src/pipe_ctrl_top.sv
dv/pipe_ctrl_tb.sv

/* Makefile */
TB  := pipe_ctrl_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module pipe_ctrl_top -f compile.f

# Pass or fail is taken from the log, not from the simulator exit code
sim:
	verilator --binary --timing --top-module $(TB) -f compile.f -o $(TB)
	./obj_dir/$(TB) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
